// ==== design/dpll_pkg.sv ====
package dpll_pkg;

  // Datapath widths
  localparam int PHASE_W = 24;                    // NCO accumulator
  localparam int ERR_W   = 16;                    // Phase error, correction, time stamps
  localparam int INT_W   = 20;                    // PI integrator
  localparam int DIV_W   = 8;                     // Feedback divide ratio

  // Nominal tuning word, about 25.6 ref_clk cycles per NCO carry
  localparam logic [PHASE_W-1:0] CENTER_WORD = 24'h0A_0000;

  // Lock criteria
  localparam int LOCK_WINDOW = 4;                 // Max |error| still in lock
  localparam int LOCK_COUNT  = 8;                 // Consecutive good errors for lock
  localparam int LOCK_CNT_W  = $clog2(LOCK_COUNT + 1); // Run counter width

  // Static loop configuration
  typedef struct packed {
    logic             loop_en;                    // Closes the loop
    logic [DIV_W-1:0] mult;                       // Divide ratio, nonzero
    logic [3:0]       kp_shift;                   // Proportional gain as right shift
    logic [3:0]       ki_shift;                   // Integral gain as right shift
  } dpll_cfg_t;

  // Observed loop state
  typedef struct packed {
    logic                      locked;            // Lock detector output
    logic signed [ERR_W-1:0]   phase_err;         // Last measured error
    logic signed [ERR_W-1:0]   correction;        // Filter output
    logic        [PHASE_W-1:0] tuning_word;       // Word the NCO is adding
  } dpll_status_t;

  // Which strobe of the current pair the detector holds
  typedef enum logic [1:0] {
    IDLE     = 2'd0,                              // Waiting for first strobe
    REF_SEEN = 2'd1,                              // Reference stamped, waiting for feedback
    FB_SEEN  = 2'd2                               // Feedback stamped, waiting for reference
  } pd_state_e;

endpackage

// ==== design/nco.sv ====
`timescale 1ns/1ps

module nco import dpll_pkg::*; (
  input  logic                    ref_clk,
  input  logic                    rst_n,
  input  logic                    loop_en,
  input  logic signed [ERR_W-1:0] correction,
  output logic                    synth_tick,
  output logic                    synth_clk,
  output logic [PHASE_W-1:0]      tuning_word
);

  logic [PHASE_W-1:0] phase_acc;                  // Phase accumulator
  logic [PHASE_W-1:0] corr_ext;                   // Sign-extended correction
  logic [PHASE_W-1:0] word_n;                     // Next tuning word
  logic [PHASE_W:0]   acc_sum;                    // Add with carry out

  // Open loop runs at the centre word only
  assign corr_ext = loop_en ? {{(PHASE_W-ERR_W){correction[ERR_W-1]}}, correction} : '0;
  assign word_n   = CENTER_WORD + corr_ext;       // Two's complement wraps correctly
  assign acc_sum  = {1'b0, phase_acc} + {1'b0, tuning_word};

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      phase_acc   <= '0;
      tuning_word <= CENTER_WORD;
      synth_tick  <= 1'b0;
    end else begin
      phase_acc   <= acc_sum[PHASE_W-1:0];
      tuning_word <= word_n;                      // Correction lands one cycle later
      synth_tick  <= acc_sum[PHASE_W];            // Carry becomes the tick
    end
  end

  assign synth_clk = phase_acc[PHASE_W-1];        // Square wave at NCO rate

  // Below half scale the accumulator needs two adds per carry
  a_tick_spaced : assert property (@(posedge ref_clk) disable iff (!rst_n)
    (synth_tick && !tuning_word[PHASE_W-1] && !$past(tuning_word[PHASE_W-1]))
      |=> !synth_tick);

endmodule

// ==== design/feedback_divider.sv ====
`timescale 1ns/1ps

module feedback_divider import dpll_pkg::*; (
  input  logic             ref_clk,
  input  logic             rst_n,
  input  logic             synth_tick,
  input  logic [DIV_W-1:0] mult,
  output logic             fb_pulse
);

  logic [DIV_W-1:0] tick_cnt;                     // Ticks seen in this period
  logic             last_tick;                    // This tick is the mult-th

  assign last_tick = ({1'b0, tick_cnt} + 1'b1) == {1'b0, mult}; // Guard bit for mult of 255

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      tick_cnt <= '0;
      fb_pulse <= 1'b0;
    end else begin
      fb_pulse <= synth_tick && last_tick;        // Strobe a cycle after the mult-th tick
      if (synth_tick) begin
        if (last_tick) tick_cnt <= '0;            // Wrap with the strobe
        else tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // A zero ratio would never strobe
  a_mult_nonzero : assert property (@(posedge ref_clk) disable iff (!rst_n)
    mult != '0);

endmodule

// ==== design/phase_detector.sv ====
`timescale 1ns/1ps

module phase_detector import dpll_pkg::*; (
  input  logic                    ref_clk,
  input  logic                    rst_n,
  input  logic                    ref_pulse,
  input  logic                    fb_pulse,
  output logic                    err_valid,
  output logic signed [ERR_W-1:0] phase_err
);

  pd_state_e        state, state_n;
  logic [ERR_W-1:0] stamp_cnt;                    // Free-running cycle counter
  logic [ERR_W-1:0] ref_stamp, ref_stamp_n;
  logic [ERR_W-1:0] fb_stamp, fb_stamp_n;
  logic             pair_done;                    // Pair completes this cycle
  logic [ERR_W:0]   stamp_diff;                   // fb - ref, one guard bit

  always_comb begin
    state_n     = state;
    ref_stamp_n = ref_stamp;
    fb_stamp_n  = fb_stamp;
    pair_done   = 1'b0;
    if (ref_pulse && fb_pulse) begin              // Coincident strobes close any pair with 0
      ref_stamp_n = stamp_cnt;
      fb_stamp_n  = stamp_cnt;
      state_n     = IDLE;
      pair_done   = 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (ref_pulse) begin
            ref_stamp_n = stamp_cnt;
            state_n     = REF_SEEN;
          end else if (fb_pulse) begin
            fb_stamp_n = stamp_cnt;
            state_n    = FB_SEEN;
          end
        end
        REF_SEEN: begin
          if (ref_pulse) ref_stamp_n = stamp_cnt; // Newer reference replaces old stamp
          else if (fb_pulse) begin
            fb_stamp_n = stamp_cnt;
            state_n    = IDLE;
            pair_done  = 1'b1;
          end
        end
        FB_SEEN: begin
          if (fb_pulse) fb_stamp_n = stamp_cnt;   // Newer feedback replaces old stamp
          else if (ref_pulse) begin
            ref_stamp_n = stamp_cnt;
            state_n     = IDLE;
            pair_done   = 1'b1;
          end
        end
        default: state_n = IDLE;
      endcase
    end
  end

  assign stamp_diff = {1'b0, fb_stamp_n} - {1'b0, ref_stamp_n}; // Positive when feedback lags

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      stamp_cnt <= '0;
      err_valid <= 1'b0;
      phase_err <= '0;
    end else begin
      state     <= state_n;
      stamp_cnt <= stamp_cnt + 1'b1;
      err_valid <= pair_done;                     // Error lands one cycle after the pair
      if (pair_done) begin
        if (stamp_diff[ERR_W] == stamp_diff[ERR_W-1]) phase_err <= stamp_diff[ERR_W-1:0];
        else if (stamp_diff[ERR_W]) phase_err <= {1'b1, {(ERR_W-1){1'b0}}}; // Clip negative
        else phase_err <= {1'b0, {(ERR_W-1){1'b1}}}; // Clip positive
      end
    end
  end

  always_ff @(posedge ref_clk) begin
    ref_stamp <= ref_stamp_n;                     // Latest stamp of each kind
    fb_stamp  <= fb_stamp_n;
  end

  // Feedback strobes are spaced by the NCO, so errors never come back to back
  a_err_single : assert property (@(posedge ref_clk) disable iff (!rst_n)
    err_valid |=> !err_valid);

endmodule

// ==== design/loop_filter.sv ====
`timescale 1ns/1ps

module loop_filter import dpll_pkg::*; (
  input  logic                    ref_clk,
  input  logic                    rst_n,
  input  logic                    loop_en,
  input  logic [3:0]              kp_shift,
  input  logic [3:0]              ki_shift,
  input  logic                    err_valid,
  input  logic signed [ERR_W-1:0] phase_err,
  output logic signed [ERR_W-1:0] correction
);

  logic signed [INT_W-1:0] integ;                 // Integral path state
  logic signed [INT_W-1:0] integ_n;               // Saturated next integrator
  logic signed [ERR_W-1:0] ki_term;               // Scaled error into integrator
  logic signed [ERR_W-1:0] kp_term;               // Scaled error, proportional path
  logic signed [INT_W:0]   int_sum;               // Integrator add, one guard bit
  logic signed [INT_W:0]   corr_sum;              // Proportional plus integral
  logic signed [ERR_W-1:0] corr_n;                // Saturated correction

  assign ki_term = phase_err >>> ki_shift;        // Arithmetic, keeps sign
  assign kp_term = phase_err >>> kp_shift;

  always_comb begin
    int_sum = {integ[INT_W-1], integ} +
              {{(INT_W + 1 - ERR_W){ki_term[ERR_W-1]}}, ki_term};
    if (int_sum[INT_W] == int_sum[INT_W-1]) begin
      integ_n = int_sum[INT_W-1:0];               // No overflow
    end else if (int_sum[INT_W]) begin
      integ_n = {1'b1, {(INT_W-1){1'b0}}};        // Pin at most negative
    end else begin
      integ_n = {1'b0, {(INT_W-1){1'b1}}};        // Pin at most positive
    end
  end

  always_comb begin
    corr_sum = {integ_n[INT_W-1], integ_n} +
               {{(INT_W + 1 - ERR_W){kp_term[ERR_W-1]}}, kp_term};
    // Fits in ERR_W when all bits above the sign agree
    if (corr_sum[INT_W:ERR_W-1] == '0 || corr_sum[INT_W:ERR_W-1] == '1) begin
      corr_n = corr_sum[ERR_W-1:0];
    end else if (corr_sum[INT_W]) begin
      corr_n = {1'b1, {(ERR_W-1){1'b0}}};
    end else begin
      corr_n = {1'b0, {(ERR_W-1){1'b1}}};
    end
  end

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      integ      <= '0;
      correction <= '0;
    end else if (!loop_en) begin                  // Open loop, filter parked at zero
      integ      <= '0;
      correction <= '0;
    end else if (err_valid) begin                 // Update only on a fresh error
      integ      <= integ_n;
      correction <= corr_n;
    end
  end

  // Opening the loop must leave the NCO at its centre word
  a_open_zero : assert property (@(posedge ref_clk) disable iff (!rst_n)
    !loop_en |=> (correction == '0));

endmodule

// ==== design/lock_detector.sv ====
`timescale 1ns/1ps

module lock_detector import dpll_pkg::*; (
  input  logic                    ref_clk,
  input  logic                    rst_n,
  input  logic                    err_valid,
  input  logic signed [ERR_W-1:0] phase_err,
  output logic                    locked
);

  logic [LOCK_CNT_W-1:0] run_cnt;                 // Consecutive in-window errors
  logic                  in_window;               // |phase_err| small enough
  logic                  run_full;                // Count has saturated

  // Signed compare against the symmetric window
  assign in_window = (phase_err >= -LOCK_WINDOW) && (phase_err <= LOCK_WINDOW);
  assign run_full  = (run_cnt == LOCK_CNT_W'(LOCK_COUNT));

  always_ff @(posedge ref_clk) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (err_valid) begin
      if (!in_window) begin
        run_cnt <= '0;                            // One bad error breaks the run
      end else if (!run_full) begin
        run_cnt <= run_cnt + 1'b1;                // Hold once saturated
      end
    end
  end

  assign locked = run_full;

  // Lock can only be gained on an error update
  a_lock_rise : assert property (@(posedge ref_clk) disable iff (!rst_n)
    $rose(locked) |-> $past(err_valid));

endmodule

// ==== design/dpll_top.sv ====
`timescale 1ns/1ps

module dpll_top import dpll_pkg::*; (
  input  logic         ref_clk,
  input  logic         rst_n,
  input  logic         ref_pulse,
  input  dpll_cfg_t    cfg,
  output logic         synth_clk,
  output logic         synth_tick,
  output logic         fb_pulse,
  output dpll_status_t status
);

  logic                    err_valid;             // Detector to filter and lock
  logic signed [ERR_W-1:0] phase_err;
  logic signed [ERR_W-1:0] correction;            // Filter to NCO
  logic [PHASE_W-1:0]      tuning_word;           // NCO word for status
  logic                    locked;

  nco u_nco (
    .ref_clk     (ref_clk),
    .rst_n       (rst_n),
    .loop_en     (cfg.loop_en),
    .correction  (correction),
    .synth_tick  (synth_tick),
    .synth_clk   (synth_clk),
    .tuning_word (tuning_word)
  );

  feedback_divider u_feedback_divider (
    .ref_clk    (ref_clk),
    .rst_n      (rst_n),
    .synth_tick (synth_tick),
    .mult       (cfg.mult),
    .fb_pulse   (fb_pulse)
  );

  phase_detector u_phase_detector (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .ref_pulse (ref_pulse),
    .fb_pulse  (fb_pulse),
    .err_valid (err_valid),
    .phase_err (phase_err)
  );

  loop_filter u_loop_filter (
    .ref_clk    (ref_clk),
    .rst_n      (rst_n),
    .loop_en    (cfg.loop_en),
    .kp_shift   (cfg.kp_shift),
    .ki_shift   (cfg.ki_shift),
    .err_valid  (err_valid),
    .phase_err  (phase_err),
    .correction (correction)
  );

  lock_detector u_lock_detector (
    .ref_clk   (ref_clk),
    .rst_n     (rst_n),
    .err_valid (err_valid),
    .phase_err (phase_err),
    .locked    (locked)
  );

  // Status view of the loop
  assign status = '{
    locked:      locked,
    phase_err:   phase_err,
    correction:  correction,
    tuning_word: tuning_word
  };

endmodule

// ==== bench/dpll_model.svh ====
`ifndef DPLL_MODEL_SVH
`define DPLL_MODEL_SVH

logic [PHASE_W-1:0] m_acc;                        // Model accumulator
logic [PHASE_W-1:0] m_word;                       // Model tuning word
logic               m_tick;
logic               m_fb;
logic [DIV_W-1:0]   m_tick_cnt;
pd_state_e          m_state;
logic [ERR_W-1:0]   m_stamp;                      // Free-running stamp counter
logic [ERR_W-1:0]   m_ref_stamp;
logic [ERR_W-1:0]   m_fb_stamp;
logic               m_err_valid;
int                 m_phase_err;
int                 m_integ;
int                 m_corr;
int                 m_run;                        // In-window run length

// Clip a value to a signed range of w bits
function automatic int saturate(input int v, input int w);
  int hi;
  int lo;
  hi = (1 <<< (w - 1)) - 1;
  lo = -(1 <<< (w - 1));
  if (v > hi) return hi;
  if (v < lo) return lo;
  return v;
endfunction

// One ref_clk edge of the whole loop, inputs as seen before the edge
task automatic model_step(input logic rst, input logic ref_in, input dpll_cfg_t c);
  logic [PHASE_W:0]   sum;
  logic [PHASE_W-1:0] word_n;
  logic               fb_n;
  pd_state_e          state_n;
  logic [ERR_W-1:0]   rs_n;
  logic [ERR_W-1:0]   fs_n;
  logic               done;
  int                 integ_n;
  int                 corr_n;
  int                 run_n;
  int                 err_n;
  if (!rst) begin
    m_acc = '0;
    m_word = CENTER_WORD;
    m_tick = 1'b0;
    m_fb = 1'b0;
    m_tick_cnt = '0;
    m_state = IDLE;
    m_stamp = '0;
    m_err_valid = 1'b0;
    m_phase_err = 0;
    m_integ = 0;
    m_corr = 0;
    m_run = 0;
  end else begin
    sum = {1'b0, m_acc} + {1'b0, m_word};
    word_n = CENTER_WORD + (c.loop_en ? PHASE_W'(m_corr) : '0); // Sign wraps in 24 bits
    fb_n = m_tick && (int'(m_tick_cnt) + 1 == int'(c.mult));
    state_n = m_state;
    rs_n = m_ref_stamp;
    fs_n = m_fb_stamp;
    done = 1'b0;
    if (ref_in && m_fb) begin                     // Coincident pair
      rs_n = m_stamp;
      fs_n = m_stamp;
      state_n = IDLE;
      done = 1'b1;
    end else if (ref_in) begin
      rs_n = m_stamp;
      done = (m_state == FB_SEEN);
      state_n = done ? IDLE : REF_SEEN;
    end else if (m_fb) begin
      fs_n = m_stamp;
      done = (m_state == REF_SEEN);
      state_n = done ? IDLE : FB_SEEN;
    end
    err_n = done ? saturate(int'(fs_n) - int'(rs_n), ERR_W) : m_phase_err;
    integ_n = m_integ;
    corr_n = m_corr;
    run_n = m_run;
    if (!c.loop_en) begin
      integ_n = 0;
      corr_n = 0;
    end else if (m_err_valid) begin
      integ_n = saturate(m_integ + (m_phase_err >>> c.ki_shift), INT_W);
      corr_n = saturate(integ_n + (m_phase_err >>> c.kp_shift), ERR_W);
    end
    if (m_err_valid) begin
      if (m_phase_err >= -LOCK_WINDOW && m_phase_err <= LOCK_WINDOW)
        run_n = (m_run < LOCK_COUNT) ? m_run + 1 : m_run;
      else
        run_n = 0;
    end
    if (m_tick) m_tick_cnt = fb_n ? '0 : m_tick_cnt + 1'b1;
    m_acc = sum[PHASE_W-1:0];
    m_word = word_n;
    m_tick = sum[PHASE_W];
    m_fb = fb_n;
    m_state = state_n;
    m_ref_stamp = rs_n;
    m_fb_stamp = fs_n;
    m_stamp = m_stamp + 1'b1;
    m_err_valid = done;
    m_phase_err = err_n;
    m_integ = integ_n;
    m_corr = corr_n;
    m_run = run_n;
  end
endtask

`endif

// ==== bench/dpll_tb.sv ====
`timescale 1ns/1ps

module dpll_tb import dpll_pkg::*; ();

  localparam int TIMEOUT = 4000;                  // Cycles allowed per wait

  logic         ref_clk;
  logic         rst_n;
  logic         ref_pulse;
  dpll_cfg_t    cfg;
  logic         synth_clk;
  logic         synth_tick;
  logic         fb_pulse;
  dpll_status_t status;

  int seed;
  int err_count;
  int checking;                                   // Per-cycle compare enabled
  int tick_seen;
  int fb_seen;
  int period;                                     // Nominal feedback period
  int adds;                                       // Accumulator adds since reset release

  `include "dpll_model.svh"

  dpll_top u_dpll_top (
    .ref_clk    (ref_clk),
    .rst_n      (rst_n),
    .ref_pulse  (ref_pulse),
    .cfg        (cfg),
    .synth_clk  (synth_clk),
    .synth_tick (synth_tick),
    .fb_pulse   (fb_pulse),
    .status     (status)
  );

  initial ref_clk = 1'b0;
  always #20 ref_clk = ~ref_clk;                  // 40 ns period

  always @(posedge ref_clk) begin
    model_step(rst_n, ref_pulse, cfg);
    if (rst_n) adds++;                            // One add per cycle out of reset
  end

  // Compare the DUT against the model
  task automatic check(input string what, input int got, input int exp);
    if (got !== exp) begin
      err_count++;
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopping at first mismatch");
    end
  endtask

  always @(negedge ref_clk) begin
    if (checking != 0) begin                      // Outputs settled mid-cycle
      check("synth_tick", int'(synth_tick), int'(m_tick));
      check("synth_clk", int'(synth_clk), int'(m_acc[PHASE_W-1]));
      check("fb_pulse", int'(fb_pulse), int'(m_fb));
      check("phase_err", int'($signed(status.phase_err)), m_phase_err);
      check("correction", int'($signed(status.correction)), m_corr);
      check("tuning_word", int'(status.tuning_word), int'(m_word));
      check("locked", int'(status.locked), int'(m_run == LOCK_COUNT));
      if (synth_tick) tick_seen++;
      if (fb_pulse) fb_seen++;
    end
  end

  task automatic next_cycle();
    @(posedge ref_clk);
    #2;                                           // Drive after the edge
  endtask

  task automatic pulse_ref();
    ref_pulse = 1'b1;
    next_cycle();
    ref_pulse = 1'b0;
  endtask

  // Step until the DUT shows a feedback strobe
  task automatic wait_fb();
    int n;
    n = 0;
    next_cycle();
    while (!fb_pulse && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!fb_pulse) begin
      $display("Some tests failed");
      $fatal(1, "Timed out waiting for a feedback strobe");
    end
  endtask

  task automatic random_refs(input int count, input int base, input int spread);
    int gap;
    repeat (count) begin
      gap = base + ($random(seed) % (spread + 1)); // base +- spread
      if (gap < 1) gap = 1;
      repeat (gap) next_cycle();
      pulse_ref();
    end
  endtask

  initial begin
    int     k;
    longint carries;                              // Open loop carries from a zero start
    seed = 92746;
    err_count = 0;
    checking = 0;
    tick_seen = 0;
    fb_seen = 0;
    adds = 0;
    rst_n = 1'b0;
    ref_pulse = 1'b0;
    cfg = '{loop_en: 1'b0, mult: 8'd4, kp_shift: 4'd2, ki_shift: 4'd4};
    cfg.mult = DIV_W'(($random(seed) & 7) + 1);   // Ratio 1 to 8
    period = (int'(cfg.mult) * (1 << PHASE_W)) / int'(CENTER_WORD);
    repeat (10) next_cycle();
    check("reset synth_tick", int'(synth_tick), 0);
    check("reset fb_pulse", int'(fb_pulse), 0);
    check("reset locked", int'(status.locked), 0);
    check("reset correction", int'(status.correction), 0);
    check("reset tuning_word", int'(status.tuning_word), int'(CENTER_WORD));
    checking = 1;
    rst_n = 1'b1;

    // Open loop, random reference with repeats
    random_refs(30, period, period - 1);
    // Counted ticks plus the one registered at the last edge
    carries = (longint'(adds) * longint'(CENTER_WORD)) >>> PHASE_W;
    check("open loop ticks", tick_seen + int'(synth_tick), int'(carries));
    // Strobes lag their mult-th tick by a cycle
    carries = (longint'(adds - 1) * longint'(CENTER_WORD)) >>> PHASE_W;
    check("open loop fb strobes", fb_seen + int'(fb_pulse), int'(carries) / int'(cfg.mult));

    // Coincident strobes give zero error
    wait_fb();
    pulse_ref();
    check("coincident error", int'($signed(status.phase_err)), 0);
    // Repeated reference replaces the stamp
    repeat (5) next_cycle();
    pulse_ref();
    repeat (3) next_cycle();
    pulse_ref();
    wait_fb();
    repeat (2) next_cycle();

    // Closed loop with random gains
    cfg.loop_en = 1'b1;
    cfg.kp_shift = 4'($random(seed) & 3);
    cfg.ki_shift = 4'(2 + ($random(seed) & 3));
    random_refs(40, period, 2);

    // Track feedback with 0 to 2 cycles of lag
    wait_fb();
    for (int i = 0; i < LOCK_COUNT + 2; i++) begin
      wait_fb();
      k = $random(seed) % 3;
      if (k < 0) k = -k;
      repeat (k) next_cycle();
      pulse_ref();
    end
    repeat (2) next_cycle();
    check("locked after jittered run", int'(status.locked), 1);
    wait_fb();
    repeat (10) next_cycle();                     // Step well outside the window
    pulse_ref();
    repeat (2) next_cycle();
    check("locked after step", int'(status.locked), 0);

    repeat (5) next_cycle();
    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+bench
design/dpll_pkg.sv
design/nco.sv
design/feedback_divider.sv
design/phase_detector.sv
design/loop_filter.sv
design/lock_detector.sv
design/dpll_top.sv
bench/dpll_tb.sv

// ==== Bender.yml ====
package:
  name: dpll

sources:
  - files:
      - design/dpll_pkg.sv
      - design/nco.sv
      - design/feedback_divider.sv
      - design/phase_detector.sv
      - design/loop_filter.sv
      - design/lock_detector.sv
      - design/dpll_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/dpll_tb.sv
